/* Bender.yml */
package:
  name: operand_store

sources:
  - design/operandPkg.sv
  - design/memAccessIf.sv
  - design/accessDecoder.sv
  - design/bitRam.sv
  - design/byteRam.sv
  - design/ioImage.sv
  - design/op2Mux.sv
  - design/operandStore.sv
  - target: simulation
    files:
      - sim/operandStore_checker.sv
      - sim/operandStoreTb.sv

/* design/accessDecoder.sv */
//////////////////////////////////////////////////////////////////////
// access decoder
// combinational decode of a valid instruction into read, write
// and immediate strobes plus space, address and data
//////////////////////////////////////////////////////////////////////

module accessDecoder
(
  input  operandPkg::inst_s                inst,
  input  logic                             instValid,
  input  logic [operandPkg::dataLen-1:0]   accIn,
  memAccessIf.decoder                      acc
);

  // space code of the instruction, used for the write filter
  operandPkg::space_e fieldSpace;

  assign fieldSpace = inst.field.access.space;

  always_comb
  begin
    // strobes idle unless a served opcode arrives
    acc.rd     = 1'b0;
    acc.wr     = 1'b0;
    acc.immLd  = 1'b0;
    // both views of the field go out, the strobes say which counts
    acc.space  = fieldSpace;
    acc.addr   = inst.field.access.addr;
    acc.imm    = inst.field.imm.data;
    acc.wrData = accIn;
    if (instValid)
    begin
      case (inst.opcode)
        operandPkg::opLd:
          acc.rd = 1'b1;
        operandPkg::opLdi:
          acc.immLd = 1'b1;
        operandPkg::opSt:
        begin
          // input image is read only
          // codes 4 to 7 have nothing to write
          acc.wr = (fieldSpace == operandPkg::spOutput) ||
                   (fieldSpace == operandPkg::spBitRam) ||
                   (fieldSpace == operandPkg::spByteRam);
        end
        default:
        begin
          // other opcodes belong to the ALU and peripherals
        end
      endcase
    end
  end

endmodule

/* design/bitRam.sv */
//////////////////////////////////////////////////////////////////////
// bit RAM
// 128 x 1 bit store with a registered read port
//////////////////////////////////////////////////////////////////////

module bitRam
(
  input  logic      clk,
  input  logic      reset,
  memAccessIf.store acc,
  output logic      bitOut
);

  // storage array, contents undefined until written
  logic mem [0:operandPkg::depth-1];
  // access aimed at this space
  logic hit;

  assign hit = (acc.space == operandPkg::spBitRam);

  // write port, only bit 0 of the accumulator is kept
  always_ff @(posedge clk)
  begin
    if (acc.wr && hit)
    begin
      mem[acc.addr] <= acc.wrData[0];
    end
  end

  // read register
  // holds its value between reads
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      bitOut <= 1'b0;
    end
    else if (acc.rd && hit)
    begin
      bitOut <= mem[acc.addr];
    end
  end

endmodule

/* design/byteRam.sv */
//////////////////////////////////////////////////////////////////////
// byte RAM
// 128 x 8 bit store with a registered read port
//////////////////////////////////////////////////////////////////////

module byteRam
(
  input  logic                           clk,
  input  logic                           reset,
  memAccessIf.store                      acc,
  output logic [operandPkg::dataLen-1:0] byteOut
);

  // storage array, no reset
  logic [operandPkg::dataLen-1:0] mem [0:operandPkg::depth-1];
  // access aimed at this space
  logic hit;

  assign hit = (acc.space == operandPkg::spByteRam);

  // write port takes the whole accumulator byte
  always_ff @(posedge clk)
  begin
    if (acc.wr && hit)
    begin
      mem[acc.addr] <= acc.wrData;
    end
  end

  // read register
  // last value kept while idle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      byteOut <= '0;
    end
    else if (acc.rd && hit)
    begin
      byteOut <= mem[acc.addr];
    end
  end

endmodule

/* design/ioImage.sv */
//////////////////////////////////////////////////////////////////////
// I/O image
// input image sampled from the pins every cycle, output image
// driven to the pins, registered single-bit read of either
//////////////////////////////////////////////////////////////////////

module ioImage
(
  input  logic                         clk,
  input  logic                         reset,
  input  logic [operandPkg::depth-1:0] inPins,
  memAccessIf.store                    acc,
  output logic [operandPkg::depth-1:0] outPins,
  output logic                         ioBitOut
);

  logic [operandPkg::depth-1:0] inImage;
  logic [operandPkg::depth-1:0] outImage;

  //////////////////////////////////////////////////////////////////////
  // images
  //////////////////////////////////////////////////////////////////////

  // pins sampled once per cycle, a read sees last cycle's value
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      inImage <= '0;
    end
    else
    begin
      inImage <= inPins;
    end
  end

  // ST to the output space sets one bit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      outImage <= '0;
    end
    else if (acc.wr && (acc.space == operandPkg::spOutput))
    begin
      outImage[acc.addr] <= acc.wrData[0];
    end
  end

  assign outPins = outImage;

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ioBitOut <= 1'b0;
    end
    else if (acc.rd)
    begin
      // other spaces leave the register alone
      if (acc.space == operandPkg::spInput)
        ioBitOut <= inImage[acc.addr];
      else if (acc.space == operandPkg::spOutput)
        ioBitOut <= outImage[acc.addr];
    end
  end

endmodule

/* design/memAccessIf.sv */
//////////////////////////////////////////////////////////////////////
// memory access bundle
// decoded strobes from the instruction decoder to the storage
// blocks and to the operand-2 multiplexer
//////////////////////////////////////////////////////////////////////

interface memAccessIf;

  // one-cycle strobes, never two at once
  logic                               rd;
  logic                               wr;
  logic                               immLd;
  // target location
  operandPkg::space_e                 space;
  logic [operandPkg::addrLen-1:0]     addr;
  // accumulator value for ST
  logic [operandPkg::dataLen-1:0]     wrData;
  // immediate for Ldi
  logic [operandPkg::dataLen-1:0]     imm;

  modport decoder (output rd, wr, immLd, space, addr, wrData, imm);

  // bitRam, byteRam, ioImage
  modport store (input rd, wr, space, addr, wrData);

  // op2Mux
  modport select (input rd, space, immLd, imm);

endinterface

/* design/op2Mux.sv */
//////////////////////////////////////////////////////////////////////
// operand-2 multiplexer
// remembers what kind of load was issued and picks the matching
// read register or immediate one cycle later
//////////////////////////////////////////////////////////////////////

module op2Mux
(
  input  logic                           clk,
  input  logic                           reset,
  memAccessIf.select                     acc,
  input  logic                           bitOut,
  input  logic                           ioBitOut,
  input  logic [operandPkg::dataLen-1:0] byteOut,
  output logic [operandPkg::dataLen-1:0] op2,
  output logic                           op2Valid
);

  // space of the last Ld
  operandPkg::space_e             ldSpace;
  // last cycle was an Ldi
  logic                           immLdQ;
  // immediate payload
  logic [operandPkg::dataLen-1:0] immQ;

  // load bookkeeping, op2Valid is a one-cycle pulse
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      op2Valid <= 1'b0;
      immLdQ   <= 1'b0;
      ldSpace  <= operandPkg::spInput;
    end
    else
    begin
      op2Valid <= acc.rd || acc.immLd;
      immLdQ   <= acc.immLd;
      if (acc.rd)
        ldSpace <= acc.space;
    end
  end

  always_ff @(posedge clk)
  begin
    if (acc.immLd)
      immQ <= acc.imm;
  end

  // select, zero while no operand is offered
  always_comb
  begin
    op2 = '0;
    if (op2Valid)
    begin
      if (immLdQ)
        op2 = immQ;
      else if (ldSpace == operandPkg::spByteRam)
        op2 = byteOut;
      else if (ldSpace == operandPkg::spBitRam)
        op2 = {{(operandPkg::dataLen-1){1'b0}}, bitOut};
      else
        // input and output images share one read register
        op2 = {{(operandPkg::dataLen-1){1'b0}}, ioBitOut};
    end
  end

endmodule

/* design/operandPkg.sv */
//////////////////////////////////////////////////////////////////////
// operand store package
// instruction format, opcodes, operand space codes and widths
// shared by the operand store blocks and the testbench
//////////////////////////////////////////////////////////////////////

package operandPkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int opcodeLen = 5;
  localparam int fieldLen  = 10;
  localparam int instLen   = opcodeLen + fieldLen;
  localparam int dataLen   = 8;
  // one 7-bit address reaches every location of every space
  localparam int addrLen   = 7;
  localparam int spaceLen  = 3;
  localparam int depth     = 1 << addrLen;

  // opcodes served by the store, all others are ignored
  localparam logic [opcodeLen-1:0] opLd  = 5'd2;
  localparam logic [opcodeLen-1:0] opLdi = 5'd3;
  localparam logic [opcodeLen-1:0] opSt  = 5'd4;

  //////////////////////////////////////////////////////////////////////
  // instruction types
  //////////////////////////////////////////////////////////////////////

  // codes 4 to 7 have no storage behind them
  typedef enum logic [spaceLen-1:0] {
    spInput   = 3'd0,
    spOutput  = 3'd1,
    spBitRam  = 3'd2,
    spByteRam = 3'd3
  } space_e;

  // Ld and ST view of the field
  typedef struct packed {
    space_e             space;
    logic [addrLen-1:0] addr;
  } accessView_s;

  // Ldi view, top bits unused
  typedef struct packed {
    logic [fieldLen-dataLen-1:0] unused;
    logic [dataLen-1:0]          data;
  } immView_s;

  typedef union packed {
    accessView_s access;
    immView_s    imm;
  } field_u;

  typedef struct packed {
    logic [opcodeLen-1:0] opcode;
    field_u               field;
  } inst_s;

endpackage

/* design/operandStore.sv */
//////////////////////////////////////////////////////////////////////
// operand store
// top level of the operand store: decoder, bit and byte RAMs,
// I/O image and the operand-2 multiplexer on plain ports
//////////////////////////////////////////////////////////////////////

module operandStore
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           instValid,
  input  operandPkg::inst_s              inst,
  input  logic [operandPkg::dataLen-1:0] accIn,
  input  logic [operandPkg::depth-1:0]   inPins,
  output logic [operandPkg::dataLen-1:0] op2,
  output logic                           op2Valid,
  output logic [operandPkg::depth-1:0]   outPins
);

  // read registers of the storage blocks
  logic                           bitOut;
  logic                           ioBitOut;
  logic [operandPkg::dataLen-1:0] byteOut;

  // decoded access shared by all blocks
  memAccessIf acc ();

  accessDecoder decoder
  (
    .inst      (inst),
    .instValid (instValid),
    .accIn     (accIn),
    .acc       (acc.decoder)
  );

  //////////////////////////////////////////////////////////////////////
  // operand spaces
  //////////////////////////////////////////////////////////////////////

  bitRam bitStore
  (
    .clk    (clk),
    .reset  (reset),
    .acc    (acc.store),
    .bitOut (bitOut)
  );

  byteRam byteStore
  (
    .clk     (clk),
    .reset   (reset),
    .acc     (acc.store),
    .byteOut (byteOut)
  );

  ioImage image
  (
    .clk      (clk),
    .reset    (reset),
    .inPins   (inPins),
    .acc      (acc.store),
    .outPins  (outPins),
    .ioBitOut (ioBitOut)
  );

  // operand-2 output stage
  op2Mux mux
  (
    .clk      (clk),
    .reset    (reset),
    .acc      (acc.select),
    .bitOut   (bitOut),
    .ioBitOut (ioBitOut),
    .byteOut  (byteOut),
    .op2      (op2),
    .op2Valid (op2Valid)
  );

endmodule

/* files.f */
design/operandPkg.sv
design/memAccessIf.sv
design/accessDecoder.sv
design/bitRam.sv
design/byteRam.sv
design/ioImage.sv
design/op2Mux.sv
design/operandStore.sv
sim/operandStore_checker.sv
sim/operandStoreTb.sv

/* sim/operandStoreTb.sv */
//////////////////////////////////////////////////////////////////////
// operand store testbench
// clock, reset, directed and random instruction stream, watchdog
//////////////////////////////////////////////////////////////////////

module operandStoreTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod    = 4;
  // byte, bit and output fills
  localparam int fillCycles   = 3 * operandPkg::depth;
  // three spaces at Ld, ST, Ld plus input at ST, Ld
  localparam int readCycles   = 11 * operandPkg::depth;
  localparam int randomCycles = 400;
  localparam int watchdogTime = (fillCycles + readCycles + randomCycles + 20) * clkPeriod;

  logic                           clk;
  logic                           reset;
  logic                           instValid;
  operandPkg::inst_s              inst;
  logic [operandPkg::dataLen-1:0] accIn;
  logic [operandPkg::depth-1:0]   inPins;
  logic [operandPkg::dataLen-1:0] op2;
  logic                           op2Valid;
  logic [operandPkg::depth-1:0]   outPins;
  integer                         seed = 69654;

  operandStore DUT
  (
    .clk       (clk),
    .reset     (reset),
    .instValid (instValid),
    .inst      (inst),
    .accIn     (accIn),
    .inPins    (inPins),
    .op2       (op2),
    .op2Valid  (op2Valid),
    .outPins   (outPins)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Ld and ST field
  function automatic logic [operandPkg::fieldLen-1:0] accessField
  (
    input logic [operandPkg::spaceLen-1:0] space,
    input logic [operandPkg::addrLen-1:0]  addr
  );
    return {space, addr};
  endfunction

  // one instruction per clock, pins change every cycle
  task automatic issue
  (
    input logic                             valid,
    input logic [operandPkg::opcodeLen-1:0] opcode,
    input logic [operandPkg::fieldLen-1:0]  field,
    input logic [operandPkg::dataLen-1:0]   data
  );
    @(posedge clk);
    instValid <= valid;
    inst      <= {opcode, field};
    accIn     <= data;
    inPins    <= {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                              a;
    int                              i;
    int                              kind;
    logic [operandPkg::spaceLen-1:0] space;
    logic [operandPkg::addrLen-1:0]  addr;
    logic [operandPkg::dataLen-1:0]  data;
    clk       = 1'b0;
    reset     = 1'b1;
    instValid = 1'b0;
    inst      = '0;
    accIn     = '0;
    inPins    = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // fill every location of the writable spaces
    for (a = 0; a < operandPkg::depth; a++)
    begin
      issue(1'b1, operandPkg::opSt, accessField(operandPkg::spByteRam, 7'(a)), $random(seed));
      issue(1'b1, operandPkg::opSt, accessField(operandPkg::spBitRam, 7'(a)), $random(seed));
      issue(1'b1, operandPkg::opSt, accessField(operandPkg::spOutput, 7'(a)), $random(seed));
    end

    // read fill value, overwrite, read back at once
    for (a = 0; a < operandPkg::depth; a++)
    begin
      for (i = 1; i <= 3; i++)
      begin
        issue(1'b1, operandPkg::opLd, accessField(3'(i), 7'(a)), 8'h00);
        issue(1'b1, operandPkg::opSt, accessField(3'(i), 7'(a)), $random(seed));
        issue(1'b1, operandPkg::opLd, accessField(3'(i), 7'(a)), 8'h00);
      end
      // input space ignores ST
      issue(1'b1, operandPkg::opSt, accessField(operandPkg::spInput, 7'(a)), 8'hff);
      issue(1'b1, operandPkg::opLd, accessField(operandPkg::spInput, 7'(a)), 8'h00);
    end

    // random mix with idle gaps
    for (i = 0; i < randomCycles; i++)
    begin
      kind  = $random(seed) & 7;
      space = $random(seed);
      // unused codes now and then
      if (space[2] && (($random(seed) & 3) != 0))
        space[2] = 1'b0;
      addr = $random(seed);
      // narrow window so ST and Ld collide
      if ($random(seed) & 1)
        addr[6:3] = '0;
      data = $random(seed);
      case (kind)
        0, 1:
          issue(1'b1, operandPkg::opLd, accessField(space, addr), data);
        2:
          issue(1'b1, operandPkg::opLdi, {2'($random(seed)), data}, $random(seed));
        3, 4:
          issue(1'b1, operandPkg::opSt, accessField(space, addr), data);
        5:
          issue(1'b1, 5'($random(seed)), accessField(space, addr), data);
        default:
          issue(1'b0, 5'($random(seed)), accessField(space, addr), data);
      endcase
    end

    // drain the last operand
    issue(1'b0, 5'd0, '0, 8'h00);
    repeat (2) @(posedge clk);
    if (DUT.check.errorCount == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      $display("Finished with errors");
      $fatal(1, "assertion failures were reported");
    end
  end

  // stop at the first failed assertion
  initial
  begin
    wait (DUT.check.errorCount != 0);
    $display("Finished with errors");
    $fatal(1, "an assertion failed, run stopped");
  end

  initial
  begin
    #(watchdogTime);
    $display("Finished with errors");
    $fatal(1, "watchdog expired before the test sequence completed");
  end

endmodule

/* sim/operandStore_checker.sv */
//////////////////////////////////////////////////////////////////////
// operand store checker
// shadow model of the four operand spaces, concurrent assertions
// on operand-2, its valid pulse and the output pins
//////////////////////////////////////////////////////////////////////

module operandStore_checker
(
  input logic                           clk,
  input logic                           reset,
  input logic                           instValid,
  input operandPkg::inst_s              inst,
  input logic [operandPkg::dataLen-1:0] accIn,
  input logic [operandPkg::depth-1:0]   inPins,
  input logic [operandPkg::dataLen-1:0] op2,
  input logic                           op2Valid,
  input logic [operandPkg::depth-1:0]   outPins
);

  timeunit 1ns;
  timeprecision 100ps;

  // zero bits above a single-bit operand
  localparam int padLen = operandPkg::dataLen - 1;

  // shadow spaces
  logic [operandPkg::depth-1:0]    inShadow;
  logic [operandPkg::depth-1:0]    outShadow;
  logic                            bitShadow [0:operandPkg::depth-1];
  logic [operandPkg::dataLen-1:0]  byteShadow [0:operandPkg::depth-1];
  // image read bit, kept across loads of unused codes
  logic                            lastIoBit;
  // expected operand-2 for this cycle
  logic                            expValid;
  logic [operandPkg::dataLen-1:0]  expOp2;
  // failures so far, polled by the testbench top
  int                              errorCount = 0;
  // decoded instruction
  logic                            isLd;
  logic                            isLdi;
  logic                            isSt;
  logic [operandPkg::spaceLen-1:0] space;
  logic [operandPkg::addrLen-1:0]  addr;

  assign isLd  = instValid && (inst.opcode == operandPkg::opLd);
  assign isLdi = instValid && (inst.opcode == operandPkg::opLdi);
  assign isSt  = instValid && (inst.opcode == operandPkg::opSt);
  assign space = inst.field.access.space;
  assign addr  = inst.field.access.addr;

  //////////////////////////////////////////////////////////////////////
  // shadow model
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      inShadow  <= '0;
      outShadow <= '0;
      lastIoBit <= 1'b0;
      expValid  <= 1'b0;
      expOp2    <= '0;
    end
    else
    begin
      // pins seen by a load one cycle later
      inShadow <= inPins;
      expValid <= isLd || isLdi;
      expOp2   <= '0;
      if (isLdi)
        expOp2 <= inst.field.imm.data;
      if (isLd)
      begin
        case (space)
          operandPkg::spInput:
          begin
            expOp2    <= {{padLen{1'b0}}, inShadow[addr]};
            lastIoBit <= inShadow[addr];
          end
          operandPkg::spOutput:
          begin
            expOp2    <= {{padLen{1'b0}}, outShadow[addr]};
            lastIoBit <= outShadow[addr];
          end
          operandPkg::spBitRam:
            expOp2 <= {{padLen{1'b0}}, bitShadow[addr]};
          operandPkg::spByteRam:
            expOp2 <= byteShadow[addr];
          default:
            // unused code, image register unchanged
            expOp2 <= {{padLen{1'b0}}, lastIoBit};
        endcase
      end
      // ST to input space or unused codes changes nothing
      if (isSt && (space == operandPkg::spOutput))
        outShadow[addr] <= accIn[0];
    end
  end

  // RAM shadows, undefined until written
  always_ff @(posedge clk)
  begin
    if (isSt && (space == operandPkg::spBitRam))
      bitShadow[addr] <= accIn[0];
    if (isSt && (space == operandPkg::spByteRam))
      byteShadow[addr] <= accIn;
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  resetCheck: assert property (@(posedge clk)
    $fell(reset) |-> (op2 == '0) && !op2Valid && (outPins == '0))
  else
  begin
    errorCount++;
    $error("CHECK FAILED reset values op2 %h op2Valid %h outPins %h, all expected 0",
           $sampled(op2), $sampled(op2Valid), $sampled(outPins));
  end

  validCheck: assert property (@(posedge clk) disable iff (reset)
    op2Valid == expValid)
  else
  begin
    errorCount++;
    $error("CHECK FAILED op2Valid expected %h actual %h",
           $sampled(expValid), $sampled(op2Valid));
  end

  op2Check: assert property (@(posedge clk) disable iff (reset)
    op2 == expOp2)
  else
  begin
    errorCount++;
    $error("CHECK FAILED op2 expected %h actual %h", $sampled(expOp2), $sampled(op2));
  end

  outPinsCheck: assert property (@(posedge clk) disable iff (reset)
    outPins == outShadow)
  else
  begin
    errorCount++;
    $error("CHECK FAILED outPins expected %h actual %h",
           $sampled(outShadow), $sampled(outPins));
  end

endmodule

bind operandStore operandStore_checker check (.*);
